//--- dv/board_tb_checks.svh
/*
 * Compare tasks, UART frame driver and display sampling helpers.
 * Included in the body of the board testbench, uses its signals.
 */

task automatic check_seg(input string name, input logic [7:0] exp_val, input logic [7:0] act_val);
	if (act_val !== exp_val) begin
		seg_errors++;
		$display("MISMATCH %s: expected %h actual %h", name, exp_val, act_val);
	end
endtask

task automatic check_led(input string name, input logic [7:0] exp_val, input logic [7:0] act_val);
	if (act_val !== exp_val) begin
		led_errors++;
		$display("MISMATCH %s: expected %b actual %b", name, exp_val, act_val);
	end
endtask

task automatic check_beep(input string name, input logic exp_val, input logic act_val);
	if (act_val !== exp_val) begin
		beep_errors++;
		$display("MISMATCH %s: expected %b actual %b", name, exp_val, act_val);
	end
endtask

// start bit, eight data bits lsb first, stop bit, then two idle bits
task automatic send_frame(input logic [7:0] value, input logic stop_bit);
	logic [9:0] frame;
	frame = {stop_bit, value, 1'b0};
	for (int i = 0; i < 10; i++) begin
		@(negedge sys_clk);
		uart_rx_port = frame[i];
		repeat (BAUD_DIV - 1) @(negedge sys_clk);
	end
	@(negedge sys_clk);
	uart_rx_port = 1'b1;
	repeat (2 * BAUD_DIV) @(negedge sys_clk);
endtask

// position of the single low bit in the digit select
function automatic int choice_index(input logic [7:0] choice);
	int idx;
	idx = 0;
	for (int i = 0; i < 8; i++) begin
		if (!choice[i]) begin
			idx = i;
		end
	end
	return idx;
endfunction

// lets the compare process see every digit once
task automatic wait_full_scan(input string name);
	int cycles;
	@(posedge sys_clk);
	test_name = name;
	seen_mask = '0;
	check_en = 1'b1;
	cycles = 0;
	while (seen_mask != 8'hFF && cycles < 16 * SCAN_CYCLES + 8) begin
		@(posedge sys_clk);
		cycles++;
	end
	check_en = 1'b0;
	if (seen_mask != 8'hFF) begin
		other_errors++;
		$display("%s: the display scan did not reach all eight digits in time", name);
	end
endtask

task automatic wait_beep_low(input string name, input int limit);
	int cycles;
	cycles = 0;
	while (beeper !== 1'b0 && cycles < limit) begin
		@(negedge sys_clk);
		cycles++;
	end
	if (beeper !== 1'b0) begin
		other_errors++;
		$display("%s: the beeper did not return low in time", name);
	end
endtask

//--- dv/board_tb.sv
/*
 * Testbench for the front-panel controller. Sends UART frames and key
 * presses, then checks leds, beeper and every scanned digit against a model.
 */
module board_tb;
	localparam int BAUD_DIV = 16;
	localparam int DEBOUNCE_CYCLES = 20;
	localparam int BEEP_CYCLES = 50;
	localparam int SCAN_CYCLES = 8;

	logic       sys_clk;
	logic       sys_rst_n;
	logic [3:0] key_in;
	logic       uart_rx_port;
	logic [7:0] led;
	logic       beeper;
	logic [7:0] seg_number;
	logic [7:0] seg_choice;

	// model of what the panel should show
	logic [7:0] exp_byte;
	logic [7:0] exp_count;
	logic [7:0] exp_presses;
	logic [3:0] exp_tog;
	logic [15:0] lfsr_q;
	logic [7:0] seen_mask;
	logic [7:0] prev_choice;
	logic       check_en;
	string      test_name;
	int         cur_idx;
	int         prev_idx;
	int         seg_errors;
	int         led_errors;
	int         beep_errors;
	int         other_errors;

	`include "board_tb_checks.svh"

	board_top #(
		.BAUD_DIV        (BAUD_DIV),
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.BEEP_CYCLES     (BEEP_CYCLES),
		.SCAN_CYCLES     (SCAN_CYCLES)
	) DUT (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.key_in       (key_in),
		.uart_rx_port (uart_rx_port),
		.led          (led),
		.beeper       (beeper),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// x^16 + x^14 + x^13 + x^11, one step per bit
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			v = {v[6:0], fb};
		end
		return v;
	endfunction

	// active low, dp off
	function automatic logic [7:0] hex_pattern(input logic [3:0] nib);
		logic [7:0] table_q [16];
		table_q = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
			8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};
		return table_q[nib];
	endfunction

	function automatic logic [7:0] expected_digit(input int d);
		case (d)
			0: return hex_pattern(exp_byte[3:0]);
			1: return hex_pattern(exp_byte[7:4]);
			2: return hex_pattern(exp_count[3:0]);
			3: return hex_pattern(exp_count[7:4]);
			6: return hex_pattern(exp_presses[3:0]);
			7: return hex_pattern(exp_presses[7:4]);
			default: return 8'hFF;
		endcase
	endfunction

	// scan order and digit contents, sampled away from the active edge
	always @(negedge sys_clk) begin
		if (sys_rst_n && seg_choice !== 8'hFF) begin
			if (!$onehot(~seg_choice)) begin
				other_errors++;
				$display("digit select %b does not have exactly one digit active", seg_choice);
			end else begin
				cur_idx = choice_index(seg_choice);
				if (prev_choice !== 8'hFF && seg_choice !== prev_choice
					&& cur_idx != (prev_idx + 1) % 8) begin
					other_errors++;
					$display("scan jumped from digit %0d to digit %0d", prev_idx, cur_idx);
				end
				if (check_en) begin
					check_seg($sformatf("%s digit %0d", test_name, cur_idx),
						expected_digit(cur_idx), seg_number);
					seen_mask[cur_idx] = 1'b1;
				end
				prev_idx = cur_idx;
			end
		end else if (sys_rst_n && prev_choice !== 8'hFF) begin
			other_errors++;
			$display("all digits went dark after scanning had started");
		end
		prev_choice = seg_choice;
	end

	initial begin
		int k;
		int len;
		logic [7:0] b;
		sys_rst_n = 1'b0;
		key_in = 4'hF;
		uart_rx_port = 1'b1;
		lfsr_q = 16'd43151;
		{exp_byte, exp_count, exp_presses, exp_tog} = '0;
		{seen_mask, check_en, prev_idx} = '0;
		prev_choice = 8'hFF;
		{seg_errors, led_errors, beep_errors, other_errors} = '0;
		test_name = "reset";
		for (int i = 0; i < 3; i++) begin
			@(negedge sys_clk);
			// release after three cycles, last pass checks just after it
			if (i == 2) begin
				sys_rst_n = 1'b1;
			end
			check_led("reset led", 8'h00, led);
			check_beep("reset beeper", 1'b0, beeper);
			check_seg("reset select", 8'hFF, seg_choice);
			check_seg("reset pattern", 8'hFF, seg_number);
		end
		wait_full_scan("reset digits");

		for (int n = 0; n < 5; n++) begin
			b = rand_bits(8);
			send_frame(b, 1'b1);
			exp_byte = b;
			exp_count++;
			wait_full_scan($sformatf("uart byte %0d", n));
		end
		send_frame(rand_bits(8), 1'b0);
		wait_full_scan("frame error");

		// glitch well below the debounce time
		k = rand_bits(2);
		len = rand_bits(3) + 2;
		@(negedge sys_clk);
		key_in[k] = 1'b0;
		repeat (len) @(negedge sys_clk);
		key_in[k] = 1'b1;
		repeat (DEBOUNCE_CYCLES + 8) begin
			@(negedge sys_clk);
			check_beep("glitch beeper", 1'b0, beeper);
		end
		check_led("glitch led", {4'h0, exp_tog}, led);
		wait_full_scan("glitch");

		for (int n = 0; n < 4; n++) begin
			k = rand_bits(2);
			len = DEBOUNCE_CYCLES + 6 + rand_bits(3);
			@(negedge sys_clk);
			key_in[k] = 1'b0;
			repeat (len) @(negedge sys_clk);
			exp_tog[k] = ~exp_tog[k];
			exp_presses++;
			check_led("press held led", {4'b0001 << k, exp_tog}, led);
			check_beep("press beeper", 1'b1, beeper);
			key_in[k] = 1'b1;
			repeat (DEBOUNCE_CYCLES + 6) @(negedge sys_clk);
			check_led("press released led", {4'h0, exp_tog}, led);
			// beep budget counts from the start of the press
			wait_beep_low("press beep",
				BEEP_CYCLES + DEBOUNCE_CYCLES + 8 - (len + DEBOUNCE_CYCLES + 6));
			wait_full_scan($sformatf("key press %0d", n));
		end

		$display("errors: seg %0d, led %0d, beep %0d, other %0d",
			seg_errors, led_errors, beep_errors, other_errors);
		if (seg_errors + led_errors + beep_errors + other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+dv
verilog/board_pkg.sv
verilog/uart_rx.sv
verilog/key_filter.sv
verilog/seg_scan.sv
verilog/board_top.sv
dv/board_tb.sv

//--- verilog/board_pkg.sv
/*
 * Shared types for the front-panel controller: receiver states, digit codes,
 * the status structs passed between blocks and the seven-segment decoder.
 */
package board_pkg;

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} rx_state_e;

	// hex digits are 0..15, so a nibble casts straight in
	typedef enum logic [4:0] {
		HEX_0, HEX_1, HEX_2, HEX_3, HEX_4, HEX_5, HEX_6, HEX_7,
		HEX_8, HEX_9, HEX_A, HEX_B, HEX_C, HEX_D, HEX_E, HEX_F,
		BLANK
	} digit_code_e;

	typedef struct packed {
		logic [7:0] data;
		logic [7:0] count;
		logic       valid;
	} uart_stat_t;

	typedef struct packed {
		logic [3:0] level;
		logic [3:0] press;
		logic [7:0] press_count;
	} key_stat_t;

	// active-low pattern, segments a..g on bits 0..6, dp kept off
	function automatic logic [7:0] seg_decode(input digit_code_e code);
		logic [6:0] seg_on;
		case (code)
			HEX_0: seg_on = 7'h3F;
			HEX_1: seg_on = 7'h06;
			HEX_2: seg_on = 7'h5B;
			HEX_3: seg_on = 7'h4F;
			HEX_4: seg_on = 7'h66;
			HEX_5: seg_on = 7'h6D;
			HEX_6: seg_on = 7'h7D;
			HEX_7: seg_on = 7'h07;
			HEX_8: seg_on = 7'h7F;
			HEX_9: seg_on = 7'h6F;
			HEX_A: seg_on = 7'h77;
			HEX_B: seg_on = 7'h7C;
			HEX_C: seg_on = 7'h39;
			HEX_D: seg_on = 7'h5E;
			HEX_E: seg_on = 7'h79;
			HEX_F: seg_on = 7'h71;
			default: seg_on = 7'h00;
		endcase
		return {1'b1, ~seg_on};
	endfunction

endpackage

//--- verilog/board_top.sv
/*
 * Front-panel controller top. Sets the timing parameters and ties the UART
 * receiver and key filter status into the display scanner.
 */
module board_top #(
	parameter int BAUD_DIV = 16,
	parameter int DEBOUNCE_CYCLES = 20,
	parameter int BEEP_CYCLES = 50,
	parameter int SCAN_CYCLES = 8
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [3:0] key_in,
	input  logic       uart_rx_port,
	output logic [7:0] led,
	output logic       beeper,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice
);
	import board_pkg::*;

	uart_stat_t rx_stat;
	key_stat_t  key_stat;

	// microcontroller link
	uart_rx #(
		.BAUD_DIV (BAUD_DIV)
	) u_uart_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.rx_stat      (rx_stat)
	);

	// keys, leds and buzzer
	key_filter #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.BEEP_CYCLES     (BEEP_CYCLES)
	) u_key_filter (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.key_stat  (key_stat),
		.led       (led),
		.beeper    (beeper)
	);

	// display, only reads status levels
	seg_scan #(
		.SCAN_CYCLES (SCAN_CYCLES)
	) u_seg_scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.rx_stat    (rx_stat),
		.key_stat   (key_stat),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

//--- verilog/key_filter.sv
/*
 * Debounces four active-low keys. Each press toggles an LED, bumps the
 * press count and (re)starts a fixed-length beep.
 */
module key_filter #(
	parameter int DEBOUNCE_CYCLES = 20,
	parameter int BEEP_CYCLES = 50
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic [3:0]           key_in,
	output board_pkg::key_stat_t key_stat,
	output logic [7:0]           led,
	output logic                 beeper
);
	localparam int DB_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [DB_W-1:0] DB_LAST = DB_W'(DEBOUNCE_CYCLES - 1);
	localparam int BEEP_W = $clog2(BEEP_CYCLES + 1);
	localparam logic [BEEP_W-1:0] BEEP_LOAD = BEEP_W'(BEEP_CYCLES);

	logic [3:0]        key_meta;
	logic [3:0]        key_sync;
	logic [3:0]        level;
	logic [3:0]        level_d;
	logic [3:0]        rise;
	logic [2:0]        rise_num;
	logic [3:0]        press_q;
	logic [3:0]        led_tog;
	logic [7:0]        press_cnt;
	logic [BEEP_W-1:0] beep_cnt;
	logic [DB_W-1:0]   db_cnt [4];

	// keys idle high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_meta <= 4'hF;
			key_sync <= 4'hF;
		end else begin
			key_meta <= key_in;
			key_sync <= key_meta;
		end
	end

	// per-key stability counter, any bounce restarts it
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			level <= '0;
			for (int k = 0; k < 4; k++) begin
				db_cnt[k] <= '0;
			end
		end else begin
			for (int k = 0; k < 4; k++) begin
				// sync is active low, so unequal means input agrees with level
				if (key_sync[k] != level[k]) begin
					db_cnt[k] <= '0;
				end else if (db_cnt[k] == DB_LAST) begin
					db_cnt[k] <= '0;
					level[k] <= ~level[k];
				end else begin
					db_cnt[k] <= db_cnt[k] + 1'b1;
				end
			end
		end
	end

	assign rise = level & ~level_d;

	// several keys may land in the same cycle
	always_comb begin
		rise_num = '0;
		for (int k = 0; k < 4; k++) begin
			rise_num = rise_num + 3'(rise[k]);
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			level_d <= '0;
			press_q <= '0;
			led_tog <= '0;
			press_cnt <= '0;
			beep_cnt <= '0;
		end else begin
			level_d <= level;
			press_q <= rise;
			led_tog <= led_tog ^ rise;
			press_cnt <= press_cnt + 8'(rise_num);
			if (|rise) begin
				beep_cnt <= BEEP_LOAD;
			end else if (beep_cnt != '0) begin
				beep_cnt <= beep_cnt - 1'b1;
			end
		end
	end

	// beep starts together with the press strobe
	assign beeper = (beep_cnt != '0);
	assign led = {level, led_tog};
	assign key_stat = '{level: level, press: press_q, press_count: press_cnt};

	a_press_level: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(key_stat.press & ~key_stat.level) == 4'b0)
		else $error("key_filter: press strobe on a released key");

endmodule

//--- verilog/seg_scan.sv
/*
 * Eight-digit seven-segment scanner. Digits 1..0 show the last UART byte,
 * 3..2 the good-byte count, 5..4 stay blank and 7..6 show the key presses.
 */
module seg_scan #(
	parameter int SCAN_CYCLES = 8
) (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  board_pkg::uart_stat_t rx_stat,
	input  board_pkg::key_stat_t  key_stat,
	output logic [7:0]            seg_number,
	output logic [7:0]            seg_choice
);
	import board_pkg::*;

	localparam int SCAN_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;
	localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SCAN_CYCLES - 1);

	digit_code_e       digit_q [8];
	logic [SCAN_W-1:0] scan_cnt;
	logic [2:0]        digit_idx;
	logic [2:0]        next_idx;
	logic              step;
	logic              scan_on;

	function automatic digit_code_e to_hex(input logic [3:0] nib);
		return digit_code_e'({1'b0, nib});
	endfunction

	// digit values follow the status every cycle
	always_ff @(posedge sys_clk) begin
		digit_q[0] <= to_hex(rx_stat.data[3:0]);
		digit_q[1] <= to_hex(rx_stat.data[7:4]);
		digit_q[2] <= to_hex(rx_stat.count[3:0]);
		digit_q[3] <= to_hex(rx_stat.count[7:4]);
		digit_q[4] <= BLANK;
		digit_q[5] <= BLANK;
		digit_q[6] <= to_hex(key_stat.press_count[3:0]);
		digit_q[7] <= to_hex(key_stat.press_count[7:4]);
	end

	assign step = (scan_cnt == SCAN_LAST);
	assign next_idx = step ? digit_idx + 3'd1 : digit_idx;

	// index starts at 7 so the first step lands on digit 0
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt <= '0;
			digit_idx <= 3'd7;
			scan_on <= 1'b0;
		end else begin
			if (step) begin
				scan_cnt <= '0;
				digit_idx <= next_idx;
				scan_on <= 1'b1;
			end else begin
				scan_cnt <= scan_cnt + 1'b1;
			end
		end
	end

	/*
	 * Pattern and select are loaded on the same edge from the same index.
	 * The pattern refreshes every cycle so a status change shows up while
	 * its digit is lit, not only on the next visit.
	 */
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seg_choice <= 8'hFF;
			seg_number <= 8'hFF;
		end else if (step || scan_on) begin
			seg_choice <= ~(8'b1 << next_idx);
			seg_number <= seg_decode(digit_q[next_idx]);
		end
	end

	a_one_digit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		scan_on |-> $onehot(~seg_choice))
		else $error("seg_scan: select is not one-hot active low");

endmodule

//--- verilog/uart_rx.sv
/*
 * 8N1 receiver for the microcontroller link. Keeps the last good byte and a
 * wrapping count of good bytes; frames with a low stop bit are dropped.
 */
module uart_rx #(
	parameter int BAUD_DIV = 16
) (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic                  uart_rx_port,
	output board_pkg::uart_stat_t rx_stat
);
	import board_pkg::*;

	localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(BAUD_DIV - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(BAUD_DIV / 2 - 1);

	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;
	rx_state_e        state;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_q;
	logic             half_end;
	logic             bit_end;
	logic             sample_bit;

	// two-flop synchroniser plus one stage for edge detect, line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= uart_rx_port;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign half_end = (baud_cnt == HALF_LAST);
	assign bit_end = (baud_cnt == BIT_LAST);
	assign sample_bit = (state == DATA) && bit_end;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			rx_stat <= '0;
		end else begin
			rx_stat.valid <= 1'b0;
			case (state)
				IDLE: begin
					baud_cnt <= '0;
					if (rx_prev && !rx_sync) begin
						state <= START;
					end
				end
				START: begin
					// re-check start bit at its middle, glitches go back to idle
					if (half_end) begin
						baud_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? IDLE : DATA;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				DATA: begin
					if (bit_end) begin
						baud_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= STOP;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				STOP: begin
					if (bit_end) begin
						baud_cnt <= '0;
						state <= IDLE;
						// good stop bit, publish the byte
						if (rx_sync) begin
							rx_stat.data <= shift_q;
							rx_stat.count <= rx_stat.count + 8'd1;
							rx_stat.valid <= 1'b1;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// lsb arrives first, so shift in from the top
	always_ff @(posedge sys_clk) begin
		if (sample_bit) begin
			shift_q <= {rx_sync, shift_q[7:1]};
		end
	end

	a_valid_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_stat.valid |=> !rx_stat.valid)
		else $error("uart_rx: valid high for more than one cycle");

	a_valid_after_stop: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(rx_stat.valid) |-> $past(state == STOP))
		else $error("uart_rx: valid raised outside a stop bit");

endmodule
